// ==== all.f ====
src/tlu_pkg.sv
src/tlu_trigger_fsm.sv
src/tlu_serial_sampler.sv
src/trigger_record.sv
src/tlu_controller.sv
dv/tlu_controller_sva.sv
dv/tlu_controller_tb.sv

// ==== Makefile ====
# Verilator build and run of the TLU trigger controller testbench

VERILATOR ?= verilator
TOP       ?= tlu_controller_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tlu_controller_tb.sv ====
// Testbench for the TLU trigger controller
// table-driven simple and TLU mode triggers, with a TLU line model
// that answers busy and shifts out the trigger number
module tlu_controller_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tlu_pkg::*;

    localparam int DIV = 4;
    localparam int MCC = 9;
    localparam int NBITS = MCC - 1;  // start bit dropped

    typedef struct {
        trigger_mode_t    mode;
        data_format_t     fmt;
        logic             msb;
        logic [CFG_W-1:0] thr;
        int               len;          // trigger high cycles in simple mode
        logic [7:0]       number;       // sent by the TLU model
        logic             tlu_release;  // 0 keeps the line high into the timeout
        int               ack_dly;
        logic             veto;
        logic             ts_rst;
    } row_t;

    logic              TRIGGER_CLK;
    logic              RESET;
    logic              trigger;
    logic              trigger_enable;
    logic              trigger_veto;
    logic              trigger_ack;
    logic              timestamp_reset;
    trigger_mode_t     trigger_mode;
    data_format_t      data_format;
    logic              msb_first;
    logic [CFG_W-1:0]  trigger_threshold;
    logic [CFG_W-1:0]  low_timeout;
    logic [CFG_W-1:0]  data_delay;
    logic              trigger_accepted;
    logic              tlu_busy;
    logic              tlu_clock_enable;
    logic              trigger_data_write;
    logic [DATA_W-1:0] trigger_data;
    logic [31:0]       timestamp;
    logic              trigger_low_timeout_error;

    row_t        rows[$];
    int          n_acc, n_wr, n_err, n_en;  // per-row event counts
    logic [31:0] ts_model;                  // expected timestamp output
    logic [31:0] ts_acc;                    // expected timestamp at the accept pulse
    logic [31:0] word_seen;
    int          exp_count;

    tlu_controller #(
        .DIVISOR          (DIV),
        .MAX_CLOCK_CYCLES (MCC),
        .TIMESTAMP_W      (32)
    ) u_tlu_controller (.*);

    initial
    begin
        TRIGGER_CLK = 1'b0;
        forever #10 TRIGGER_CLK = ~TRIGGER_CLK;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else stop_with_error($sformatf("Mismatch %s: got 0x%08h expected 0x%08h",
                                       name, got, exp));
    endtask

    // one falling edge where the outputs are stable
    task automatic sample_cycle();
        logic clear;
        clear = timestamp_reset;  // value seen by the coming rising edge
        @(negedge TRIGGER_CLK);
        ts_model = clear ? 32'd0 : ts_model + 32'd1;
        check_hex("timestamp", timestamp, ts_model);
        if (trigger_accepted)
        begin
            n_acc++;
            ts_acc = ts_model;
        end
        if (trigger_data_write)
        begin
            n_wr++;
            word_seen = trigger_data;
        end
        if (trigger_low_timeout_error)
            n_err++;
        if (tlu_clock_enable)
            n_en++;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int guard;
        guard = 0;
        while (tlu_busy !== level)
        begin
            sample_cycle();
            guard++;
            assert (guard < 100) else stop_with_error(what);
        end
    endtask

    task automatic wait_clock_enable();
        int guard;
        guard = 0;
        while (tlu_clock_enable !== 1'b1)
        begin
            sample_cycle();
            guard++;
            assert (guard < 100) else stop_with_error("tlu_clock_enable never went high");
        end
    endtask

    task automatic wait_data_write();
        int guard;
        guard = 0;
        while (n_wr == 0)
        begin
            sample_cycle();
            guard++;
            assert (guard < 200) else stop_with_error("no data word written after accept");
        end
    endtask

    function automatic logic [31:0] expected_word(input row_t r, input logic [31:0] ts,
                                                  input logic [31:0] count);
        logic [31:0] num;
        num = (r.mode == mode_tlu_number) ? {24'h0, r.number} : count;
        if (r.fmt == fmt_timestamp)
            return {1'b1, ts[30:0]};
        else if (r.fmt == fmt_combined)
            return {1'b1, ts[14:0], num[15:0]};
        else
            return {1'b1, num[30:0]};  // 2'b11 also gives the number
    endfunction

    // bit sent in slot k for k >= 1
    function automatic logic tlu_bit(input row_t r, input int k);
        return r.msb ? r.number[NBITS-k] : r.number[k-1];
    endfunction

    function automatic int short_ack();
        return int'($urandom % 4);
    endfunction

    function automatic void add_row(input trigger_mode_t mode, input data_format_t fmt,
                                    input logic msb, input logic [CFG_W-1:0] thr,
                                    input int len, input logic rel, input int ack_dly,
                                    input logic veto, input logic ts_rst);
        row_t r;
        r.mode = mode;
        r.fmt = fmt;
        r.msb = msb;
        r.thr = thr;
        r.len = len;
        r.number = 8'($urandom);
        r.tlu_release = rel;
        r.ack_dly = ack_dly;
        r.veto = veto;
        r.ts_rst = ts_rst;
        rows.push_back(r);
    endfunction

    task automatic restart_timestamp();
        timestamp_reset = 1'b1;
        sample_cycle();
        check_hex("timestamp", timestamp, 32'd0);
        timestamp_reset = 1'b0;
        sample_cycle();
        check_hex("timestamp", timestamp, 32'd1);
    endtask

    task automatic pulse_trigger(input int len);
        trigger = 1'b1;
        repeat (len) sample_cycle();
        trigger = 1'b0;
        repeat (3) sample_cycle();  // late accepts would show here
    endtask

    // TLU side raises the line, drops it on busy, then sends start bit and number
    task automatic tlu_handshake(input row_t r);
        int k;
        trigger = 1'b1;
        wait_busy(1'b1, "tlu_busy did not answer the TLU trigger");
        if (r.tlu_release)
            trigger = 1'b0;
        wait_clock_enable();
        for (k = 0; k < MCC; k++)
        begin
            trigger = (k == 0) ? 1'b1 : tlu_bit(r, k);
            repeat (DIV) sample_cycle();
        end
        trigger = 1'b0;
    endtask

    task automatic release_with_ack(input int dly);
        int c;
        for (c = 0; c < dly; c++)
        begin
            sample_cycle();
            assert (tlu_busy) else stop_with_error("tlu_busy dropped before the acknowledge");
            trigger = (dly >= 10 && c >= 3 && c < 6);  // pulse while blocked
        end
        trigger = 1'b0;
        trigger_ack = 1'b1;
        sample_cycle();
        trigger_ack = 1'b0;
        wait_busy(1'b0, "tlu_busy did not drop after the acknowledge");
    endtask

    task automatic run_row(input row_t r);
        logic        expect_acc;
        logic [31:0] exp_word;
        expect_acc = (r.mode == mode_tlu_number)
                     || (r.mode == mode_simple && !r.veto && r.len > int'(r.thr));
        trigger_mode = r.mode;
        data_format = r.fmt;
        msb_first = r.msb;
        trigger_threshold = r.thr;
        trigger_veto = r.veto;
        n_acc = 0;
        n_wr = 0;
        n_err = 0;
        n_en = 0;
        if (r.ts_rst)
            restart_timestamp();
        else
            sample_cycle();
        if (r.mode == mode_tlu_number)
            tlu_handshake(r);
        else
            pulse_trigger(r.len);
        if (expect_acc)
        begin
            wait_data_write();
            release_with_ack(r.ack_dly);
            exp_word = expected_word(r, ts_acc, exp_count);
            check_hex("trigger_accepted pulses", n_acc, 32'd1);
            check_hex("trigger_data_write pulses", n_wr, 32'd1);
            check_hex("trigger_data", word_seen, exp_word);
            check_hex("trigger_data", trigger_data, exp_word);  // held until the next accept
            if (r.mode == mode_tlu_number)
            begin
                check_hex("tlu_clock_enable cycles", n_en, MCC * DIV);
                check_hex("trigger_low_timeout_error pulses", n_err,
                          r.tlu_release ? 32'd0 : 32'd1);
            end
            exp_count++;
        end
        else
        begin
            check_hex("trigger_accepted pulses", n_acc, 32'd0);
            check_hex("trigger_data_write pulses", n_wr, 32'd0);
            assert (!tlu_busy) else stop_with_error("tlu_busy high without an accept");
        end
        trigger_veto = 1'b0;
    endtask

    initial
    begin
        void'($urandom(32'hf0d555d7));
        RESET = 1'b1;
        trigger = 1'b0;
        trigger_enable = 1'b1;
        trigger_veto = 1'b0;
        trigger_ack = 1'b0;
        timestamp_reset = 1'b0;
        trigger_mode = mode_simple;
        data_format = fmt_number;
        msb_first = 1'b0;
        trigger_threshold = '0;
        low_timeout = 8'd12;
        data_delay = 8'd3;
        exp_count = 0;
        ts_model = 32'd0;

        // mode, format, msb, threshold, length, release, ack delay, veto, ts reset
        add_row(mode_simple, fmt_number, 1'b0, 8'd0, 2, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_simple, fmt_timestamp, 1'b0, 8'd0, 1, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_simple, fmt_combined, 1'b0, 8'd0, 3, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_simple, fmt_number, 1'b0, 8'd3, 3, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_simple, fmt_number, 1'b0, 8'd3, 5, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_simple, fmt_number, 1'b0, 8'd0, 2, 1'b1, short_ack(), 1'b1, 1'b0);
        add_row(mode_tlu_number, fmt_number, 1'b1, 8'd0, 1, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_tlu_number, fmt_number, 1'b0, 8'd0, 1, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_tlu_number, fmt_combined, 1'b1, 8'd0, 1, 1'b1, short_ack(), 1'b0, 1'b0);
        add_row(mode_tlu_number, fmt_combined, 1'b0, 8'd0, 1, 1'b1, short_ack(), 1'b1, 1'b0);
        add_row(mode_simple, fmt_number, 1'b0, 8'd0, 2, 1'b1, 25 + short_ack(), 1'b0, 1'b0);
        add_row(mode_tlu_number, fmt_number, 1'b1, 8'd0, 1, 1'b0, short_ack(), 1'b0, 1'b0);
        add_row(mode_simple, fmt_timestamp, 1'b0, 8'd0, 2, 1'b1, short_ack(), 1'b0, 1'b1);
        add_row(trigger_mode_t'(2'b01), fmt_number, 1'b0, 8'd0, 2, 1'b1, 0, 1'b0, 1'b0);
        add_row(mode_simple, data_format_t'(2'b11), 1'b0, 8'd0, 2, 1'b1, 1, 1'b0, 1'b0);

        repeat (4) @(negedge TRIGGER_CLK);
        RESET = 1'b0;
        foreach (rows[i])
            run_row(rows[i]);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== dv/tlu_controller_sva.sv ====
// Protocol assertions for the TLU trigger controller
// pulse widths, clock enable inside busy, data word marker bit
module tlu_controller_sva (
    input logic                       TRIGGER_CLK,
    input logic                       RESET,
    input logic                       trigger_accepted,
    input logic                       trigger_data_write,
    input logic                       tlu_busy,
    input logic                       tlu_clock_enable,
    input logic [tlu_pkg::DATA_W-1:0] trigger_data
);
    timeunit 1ns;
    timeprecision 1ps;

    accept_single: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_accepted |=> !trigger_accepted)
        else $error("trigger_accepted high for more than one cycle");

    write_single: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_data_write |=> !trigger_data_write)
        else $error("trigger_data_write high for more than one cycle");

    clock_in_busy: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        tlu_clock_enable |-> tlu_busy)
        else $error("tlu_clock_enable high while not busy");

    // every data word carries the marker bit
    word_marker: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_data_write |-> trigger_data[31])
        else $error("trigger_data bit 31 clear during a write");

endmodule

bind tlu_controller tlu_controller_sva u_sva (.*);

// ==== src/tlu_controller.sv ====
// TLU trigger controller top level
// trigger FSM, serial number sampler and data word record
module tlu_controller #(
    parameter int DIVISOR          = 8,
    parameter int MAX_CLOCK_CYCLES = 17,
    parameter int TIMESTAMP_W      = 32
) (
    input  logic                       TRIGGER_CLK,
    input  logic                       RESET,
    input  logic                       trigger,
    input  logic                       trigger_enable,
    input  logic                       trigger_veto,
    input  logic                       trigger_ack,
    input  logic                       timestamp_reset,
    input  tlu_pkg::trigger_mode_t     trigger_mode,
    input  tlu_pkg::data_format_t      data_format,
    input  logic                       msb_first,
    input  logic [tlu_pkg::CFG_W-1:0]  trigger_threshold,
    input  logic [tlu_pkg::CFG_W-1:0]  low_timeout,
    input  logic [tlu_pkg::CFG_W-1:0]  data_delay,
    output logic                       trigger_accepted,
    output logic                       tlu_busy,
    output logic                       tlu_clock_enable,
    output logic                       trigger_data_write,
    output logic [tlu_pkg::DATA_W-1:0] trigger_data,
    output logic [TIMESTAMP_W-1:0]     timestamp,
    output logic                       trigger_low_timeout_error
);
    import tlu_pkg::*;

    logic [DATA_W-1:0] tlu_number;  // sampler to record

    tlu_trigger_fsm #(
        .DIVISOR          (DIVISOR),
        .MAX_CLOCK_CYCLES (MAX_CLOCK_CYCLES)
    ) u_fsm (
        .TRIGGER_CLK               (TRIGGER_CLK),
        .RESET                     (RESET),
        .trigger                   (trigger),
        .trigger_enable            (trigger_enable),
        .trigger_veto              (trigger_veto),
        .trigger_ack               (trigger_ack),
        .trigger_mode              (trigger_mode),
        .trigger_threshold         (trigger_threshold),
        .low_timeout               (low_timeout),
        .data_delay                (data_delay),
        .trigger_accepted          (trigger_accepted),
        .tlu_busy                  (tlu_busy),
        .tlu_clock_enable          (tlu_clock_enable),
        .trigger_data_write        (trigger_data_write),
        .trigger_low_timeout_error (trigger_low_timeout_error)
    );

    tlu_serial_sampler #(
        .DIVISOR          (DIVISOR),
        .MAX_CLOCK_CYCLES (MAX_CLOCK_CYCLES)
    ) u_sampler (
        .TRIGGER_CLK      (TRIGGER_CLK),
        .RESET            (RESET),
        .trigger          (trigger),
        .tlu_clock_enable (tlu_clock_enable),
        .trigger_accepted (trigger_accepted),
        .msb_first        (msb_first),
        .tlu_number       (tlu_number)
    );

    trigger_record #(
        .TIMESTAMP_W (TIMESTAMP_W)
    ) u_record (
        .TRIGGER_CLK        (TRIGGER_CLK),
        .RESET              (RESET),
        .trigger_accepted   (trigger_accepted),
        .trigger_data_write (trigger_data_write),
        .timestamp_reset    (timestamp_reset),
        .trigger_mode       (trigger_mode),
        .data_format        (data_format),
        .tlu_number         (tlu_number),
        .timestamp          (timestamp),
        .trigger_data       (trigger_data)
    );

endmodule

// ==== src/trigger_record.sv ====
// Trigger record
// timestamp and accepted-trigger counters, latched at the accept pulse,
// and the formatted 32-bit data word
module trigger_record #(
    parameter int TIMESTAMP_W = 32
) (
    input  logic                       TRIGGER_CLK,
    input  logic                       RESET,
    input  logic                       trigger_accepted,
    input  logic                       trigger_data_write,
    input  logic                       timestamp_reset,
    input  tlu_pkg::trigger_mode_t     trigger_mode,
    input  tlu_pkg::data_format_t      data_format,
    input  logic [tlu_pkg::DATA_W-1:0] tlu_number,
    output logic [TIMESTAMP_W-1:0]     timestamp,
    output logic [tlu_pkg::DATA_W-1:0] trigger_data
);
    import tlu_pkg::*;

    logic [DATA_W-1:0]      trig_count;  // triggers accepted since reset
    logic [DATA_W-1:0]      count_q;
    logic [TIMESTAMP_W-1:0] ts_q;
    logic [DATA_W-1:0]      number_sel;
    logic [DATA_W-1:0]      word;
    logic [DATA_W-1:0]      word_q;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || timestamp_reset)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trig_count <= '0;
        else if (trigger_accepted)
            trig_count <= trig_count + 1'b1;
    end

    // snapshot closest to the trigger
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (trigger_accepted)
        begin
            ts_q    <= timestamp;
            count_q <= trig_count; // count before this trigger
        end
    end

    assign number_sel = (trigger_mode == mode_tlu_number) ? tlu_number : count_q;

    always_comb
    begin
        case (data_format)
            fmt_timestamp:
                word = {1'b1, ts_q[30:0]};
            fmt_combined:
                word = {1'b1, ts_q[14:0], number_sel[15:0]};
            default:
                word = {1'b1, number_sel[30:0]}; // number only, also 2'b11
        endcase
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (trigger_data_write)
            word_q <= word;
    end

    // valid already in the write cycle, then held
    assign trigger_data = trigger_data_write ? word : word_q;

endmodule

// ==== src/tlu_serial_sampler.sv ====
// TLU serial number sampler
// picks one mid-slot sample per TLU clock period and drops the start bit
module tlu_serial_sampler #(
    parameter int DIVISOR          = 8,
    parameter int MAX_CLOCK_CYCLES = 17
) (
    input  logic                       TRIGGER_CLK,
    input  logic                       RESET,
    input  logic                       trigger,
    input  logic                       tlu_clock_enable,
    input  logic                       trigger_accepted,
    input  logic                       msb_first,
    output logic [tlu_pkg::DATA_W-1:0] tlu_number
);
    import tlu_pkg::*;

    localparam int NUM_BITS = MAX_CLOCK_CYCLES - 1;
    localparam int PHASE_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
    localparam int SLOT_W = $clog2(MAX_CLOCK_CYCLES + 1);
    localparam logic [PHASE_W-1:0] SAMPLE_AT = PHASE_W'(DIVISOR / 2);
    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(DIVISOR - 1);

    logic [PHASE_W-1:0]  phase;    // cycle within the slot
    logic [SLOT_W-1:0]   slot;
    logic [NUM_BITS-1:0] shift_q;  // first received bit ends up on top
    logic [NUM_BITS-1:0] ordered;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || !tlu_clock_enable)
        begin
            phase <= '0;
            slot  <= '0;
        end
        else if (phase == LAST_PHASE)
        begin
            phase <= '0;
            slot  <= slot + 1'b1;
        end
        else
            phase <= phase + 1'b1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (trigger_accepted)
            shift_q <= '0;
        else if (tlu_clock_enable && phase == SAMPLE_AT && slot != '0) // slot 0 is the start bit
            shift_q <= {shift_q[NUM_BITS-2:0], trigger};
    end

    always_comb
    begin
        for (int i = 0; i < NUM_BITS; i++)
            ordered[i] = msb_first ? shift_q[i] : shift_q[NUM_BITS-1-i];
    end

    assign tlu_number = DATA_W'(ordered); // zero-extended

endmodule

// ==== src/tlu_trigger_fsm.sv ====
// Trigger FSM
// accepts a filtered level trigger or a TLU handshake and sequences
// busy, TLU clock, latch and acknowledge wait
module tlu_trigger_fsm #(
    parameter int DIVISOR          = 8,
    parameter int MAX_CLOCK_CYCLES = 17
) (
    input  logic                      TRIGGER_CLK,
    input  logic                      RESET,
    input  logic                      trigger,
    input  logic                      trigger_enable,
    input  logic                      trigger_veto,
    input  logic                      trigger_ack,
    input  tlu_pkg::trigger_mode_t    trigger_mode,
    input  logic [tlu_pkg::CFG_W-1:0] trigger_threshold,
    input  logic [tlu_pkg::CFG_W-1:0] low_timeout,
    input  logic [tlu_pkg::CFG_W-1:0] data_delay,
    output logic                      trigger_accepted,
    output logic                      tlu_busy,
    output logic                      tlu_clock_enable,
    output logic                      trigger_data_write,
    output logic                      trigger_low_timeout_error
);
    import tlu_pkg::*;

    localparam int CLK_TOTAL = MAX_CLOCK_CYCLES * DIVISOR;
    localparam int CLK_CNT_W = $clog2(CLK_TOTAL + 1);

    fsm_state_t state;
    fsm_state_t next;

    logic                 trigger_ff;
    logic                 trigger_flag;
    logic [CFG_W-1:0]     high_cnt;     // consecutive high samples since the edge
    logic [CFG_W-1:0]     low_cnt;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [CFG_W:0]       wait_cnt;
    logic [CFG_W:0]       wait_total;
    logic                 ack_seen;
    logic                 simple_go;
    logic                 tlu_go;
    logic                 timeout_hit;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_ff <= 1'b0;
        else
            trigger_ff <= trigger;
    end

    assign trigger_flag = trigger & ~trigger_ff; // rising edge seen at this sample

    // high-time filter, only counts in idle and only from a rising edge
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || state != st_idle)
            high_cnt <= '0;
        else if (trigger_flag || (trigger && high_cnt != '0))
        begin
            if (high_cnt != '1)
                high_cnt <= high_cnt + 1'b1; // saturate
        end
        else
            high_cnt <= '0;
    end

    assign simple_go = (trigger_mode == mode_simple) && trigger_enable && !trigger_veto
                       && ((trigger_threshold == '0) ? trigger_flag
                                                     : (trigger && high_cnt >= trigger_threshold));
    assign tlu_go = (trigger_mode == mode_tlu_number) && trigger_enable && trigger_flag;

    assign timeout_hit = (low_timeout != '0) && (low_cnt >= low_timeout);
    assign wait_total = {1'b0, data_delay} + (CFG_W + 1)'(LATCH_EXTRA_WAIT);

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            state <= st_idle;
        else
            state <= next;
    end

    always_comb
    begin
        next = state;
        case (state)
            st_idle:
            begin
                if (simple_go)
                    next = st_capture;
                else if (tlu_go)
                    next = st_wait_trigger_low;
            end
            st_capture:
                next = st_latch;
            st_wait_trigger_low:
            begin
                if (!trigger || timeout_hit)
                    next = st_send_clock;
            end
            st_send_clock:
            begin
                if (clk_cnt >= CLK_CNT_W'(CLK_TOTAL))
                    next = st_wait_before_latch;
            end
            st_wait_before_latch:
            begin
                if (wait_cnt >= wait_total)
                    next = st_latch;
            end
            st_latch:
                next = st_wait_ack;
            st_wait_ack:
            begin
                if (ack_seen)
                    next = st_idle;
            end
            default:
                next = st_idle;
        endcase
    end

    // outputs and counters follow the next state
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            trigger_accepted          <= 1'b0;
            tlu_busy                  <= 1'b0;
            tlu_clock_enable          <= 1'b0;
            trigger_data_write        <= 1'b0;
            trigger_low_timeout_error <= 1'b0;
            ack_seen                  <= 1'b0;
            low_cnt                   <= '0;
            clk_cnt                   <= '0;
            wait_cnt                  <= '0;
        end
        else
        begin
            trigger_accepted   <= (state == st_idle) && (next != st_idle);
            tlu_busy           <= (next != st_idle);
            tlu_clock_enable   <= (next == st_send_clock);
            trigger_data_write <= (next == st_latch);
            // line still high when leaving means the timeout ended the wait
            trigger_low_timeout_error <= (state == st_wait_trigger_low)
                                         && (next == st_send_clock) && trigger;
            ack_seen <= (next == st_idle) ? 1'b0 : (ack_seen | trigger_ack);
            low_cnt  <= (next == st_wait_trigger_low) ? low_cnt + 1'b1 : '0;
            clk_cnt  <= (next == st_send_clock) ? clk_cnt + 1'b1 : '0;
            wait_cnt <= (next == st_wait_before_latch) ? wait_cnt + 1'b1 : '0;
        end
    end

endmodule

// ==== src/tlu_pkg.sv ====
// TLU trigger controller package
// shared widths, mode and data format codes, and the trigger FSM states
package tlu_pkg;

    localparam int DATA_W = 32;           // output data word
    localparam int CFG_W = 8;             // threshold, timeout and delay settings
    localparam int LATCH_EXTRA_WAIT = 5;  // added to data_delay before the latch

    // codes 2'b01 and 2'b10 are not used and accept nothing
    typedef enum logic [1:0] {
        mode_simple     = 2'b00,  // level trigger, optional high-time filter
        mode_tlu_number = 2'b11   // TLU handshake with serial number readout
    } trigger_mode_t;

    // 2'b11 is treated like fmt_number
    typedef enum logic [1:0] {
        fmt_number    = 2'b00,  // trigger number only
        fmt_timestamp = 2'b01,  // timestamp only
        fmt_combined  = 2'b10   // timestamp 14:0 over number 15:0
    } data_format_t;

    typedef enum logic [2:0] {
        st_idle              = 3'd0,
        st_capture           = 3'd1,  // simple mode, one cycle before latch
        st_wait_trigger_low  = 3'd2,  // TLU holds the line high until busy seen
        st_send_clock        = 3'd3,
        st_wait_before_latch = 3'd4,
        st_latch             = 3'd5,
        st_wait_ack          = 3'd6
    } fsm_state_t;

endpackage
